// ==== rtl/accel_pkg.sv ====
`default_nettype none

package accel_pkg;

    //////////////////////////////////////////////////////////////////////
    // default geometry
    //////////////////////////////////////////////////////////////////////

    // one memory row holds N_LANES signed lanes
    localparam int N_LANES        = 15;
    localparam int LANE_WIDTH     = 8;
    localparam int ROW_WIDTH      = N_LANES * LANE_WIDTH;

    // DRAM side
    localparam int WORD_WIDTH     = 32;
    localparam int WORDS_PER_ROW  = (ROW_WIDTH + WORD_WIDTH - 1) / WORD_WIDTH;

    // 64 rows per operand memory
    localparam int ROW_ADDR_WIDTH = 6;
    localparam int ACC_WIDTH      = 24;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [LANE_WIDTH-1:0] lane_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    // steers an incoming word to one of the two operand memories
    typedef enum logic {
        TGT_FEATURE = 1'b0,
        TGT_WEIGHT  = 1'b1
    } mem_target_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        STREAM = 2'd1,
        DRAIN  = 2'd2,
        DONE   = 2'd3
    } engine_state_e;

endpackage

`default_nettype wire

// ==== rtl/row_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// read side of one operand memory
interface row_port_if #(
    parameter int ROW_ADDR_WIDTH = accel_pkg::ROW_ADDR_WIDTH,
    parameter int ROW_WIDTH      = accel_pkg::ROW_WIDTH
);

    logic                      rd_en;
    logic [ROW_ADDR_WIDTH-1:0] rd_addr;
    // valid one cycle after rd_en, held until the next read
    logic [ROW_WIDTH-1:0]      rd_data;
    // one extra bit so a full memory can be counted
    logic [ROW_ADDR_WIDTH:0]   row_count;

    modport loader (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output row_count
    );

    modport engine (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  row_count
    );

endinterface

`default_nettype wire

// ==== rtl/row_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_packer #(
    parameter int ROW_WIDTH = accel_pkg::ROW_WIDTH
) (
    input  logic                             clk_i,
    input  logic                             rd_weight_rst,
    input  logic                             clear_i,
    input  logic                             word_valid_i,
    input  logic [accel_pkg::WORD_WIDTH-1:0] word_i,
    output logic                             row_write_o,
    output logic [ROW_WIDTH-1:0]             row_data_o
);

    import accel_pkg::*;

    localparam int N_WORDS   = (ROW_WIDTH + WORD_WIDTH - 1) / WORD_WIDTH;
    localparam int CNT_WIDTH = (N_WORDS > 1) ? $clog2(N_WORDS) : 1;
    localparam int BUF_WIDTH = N_WORDS * WORD_WIDTH;
    localparam logic [CNT_WIDTH-1:0] LAST_WORD = CNT_WIDTH'(N_WORDS - 1);

    logic [CNT_WIDTH-1:0] word_cnt_q;
    logic [BUF_WIDTH-1:0] shift_q;
    logic                 row_write_q;
    logic                 last_word;

    assign last_word = word_valid_i && (word_cnt_q == LAST_WORD);

    // word counter and write strobe
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            word_cnt_q  <= '0;
            row_write_q <= 1'b0;
        end else if (clear_i) begin
            // partial row is thrown away
            word_cnt_q  <= '0;
            row_write_q <= 1'b0;
        end else begin
            row_write_q <= last_word;
            if (last_word) begin
                word_cnt_q <= '0;
            end else if (word_valid_i) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
        end
    end

    // words enter at the top and move down, so word 0 lands in the low bits
    always_ff @(posedge clk_i) begin
        if (word_valid_i) begin
            shift_q <= {word_i, shift_q[BUF_WIDTH-1:WORD_WIDTH]};
        end
    end

    assign row_write_o = row_write_q;
    // spare bits of the last word fall off here
    assign row_data_o  = shift_q[ROW_WIDTH-1:0];

    a_single_write: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        row_write_o |=> !row_write_o)
        else $error("row_packer: back-to-back row writes");

endmodule

`default_nettype wire

// ==== rtl/row_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_loader #(
    parameter int N_LANES        = accel_pkg::N_LANES,
    parameter int LANE_WIDTH     = accel_pkg::LANE_WIDTH,
    parameter int ROW_ADDR_WIDTH = accel_pkg::ROW_ADDR_WIDTH
) (
    input  logic                             clk_i,
    input  logic                             rd_weight_rst,
    input  logic                             clear_i,
    input  logic                             word_valid_i,
    input  logic [accel_pkg::WORD_WIDTH-1:0] word_i,
    row_port_if.loader                       port_o
);

    localparam int ROW_WIDTH = N_LANES * LANE_WIDTH;
    localparam int DEPTH     = 2 ** ROW_ADDR_WIDTH;

    logic                      row_write;
    logic [ROW_WIDTH-1:0]      row_data;
    logic [ROW_ADDR_WIDTH-1:0] wr_ptr_q;
    logic [ROW_ADDR_WIDTH:0]   row_count_q;
    logic                      mem_full;
    logic                      wr_en;

    logic [ROW_WIDTH-1:0]      mem_q [DEPTH];

    row_packer #(
        .ROW_WIDTH (ROW_WIDTH)
    ) i_row_packer (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .clear_i       (clear_i),
        .word_valid_i  (word_valid_i),
        .word_i        (word_i),
        .row_write_o   (row_write),
        .row_data_o    (row_data)
    );

    // count saturates at DEPTH, so its top bit alone marks a full memory
    assign mem_full = row_count_q[ROW_ADDR_WIDTH];
    assign wr_en    = row_write && !mem_full && !clear_i;

    //////////////////////////////////////////////////////////////////////
    // write pointer and row count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            wr_ptr_q    <= '0;
            row_count_q <= '0;
        end else if (clear_i) begin
            wr_ptr_q    <= '0;
            row_count_q <= '0;
        end else if (wr_en) begin
            wr_ptr_q    <= wr_ptr_q + 1'b1;
            row_count_q <= row_count_q + 1'b1;
        end
    end

    assign port_o.row_count = row_count_q;

    //////////////////////////////////////////////////////////////////////
    // dual-port row memory
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= row_data;
        end
    end

    // registered read, data held between reads
    always_ff @(posedge clk_i) begin
        if (port_o.rd_en) begin
            port_o.rd_data <= mem_q[port_o.rd_addr];
        end
    end

    a_count_bound: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        row_count_q <= DEPTH)
        else $error("row_loader: row count beyond memory depth");

endmodule

`default_nettype wire

// ==== rtl/dot_product_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module dot_product_engine #(
    parameter int N_LANES        = accel_pkg::N_LANES,
    parameter int LANE_WIDTH     = accel_pkg::LANE_WIDTH,
    parameter int ROW_ADDR_WIDTH = accel_pkg::ROW_ADDR_WIDTH,
    parameter int ACC_WIDTH      = accel_pkg::ACC_WIDTH
) (
    input  logic            clk_i,
    input  logic            rd_weight_rst,
    input  logic            start_i,
    row_port_if.engine      feature_port_i,
    row_port_if.engine      weight_port_i,
    output logic            busy_o,
    output logic            result_valid_o,
    output accel_pkg::acc_t final_output_o
);

    import accel_pkg::*;

    localparam int PROD_WIDTH = 2 * LANE_WIDTH;
    localparam logic [ROW_ADDR_WIDTH:0] ROW_ONE = 1;

    engine_state_e                state_q;
    logic [ROW_ADDR_WIDTH:0]      rows_q;
    logic [ROW_ADDR_WIDTH:0]      min_count;
    logic [ROW_ADDR_WIDTH-1:0]    rd_addr_q;
    logic                         rd_en;
    logic                         last_read;
    logic                         rd_valid_q;
    logic                         sum_valid_q;
    logic signed [ACC_WIDTH-1:0]  row_sum;
    logic signed [ACC_WIDTH-1:0]  sum_q;
    logic signed [ACC_WIDTH-1:0]  acc_q;

    // the result port is the package accumulator type
    if (ACC_WIDTH != $bits(acc_t)) begin : g_acc_width_check
        $error("dot_product_engine: ACC_WIDTH does not match acc_t");
    end

    assign min_count = (feature_port_i.row_count < weight_port_i.row_count) ?
                       feature_port_i.row_count : weight_port_i.row_count;

    // with R of zero STREAM still takes one cycle, which keeps latency at R+3
    assign rd_en     = (state_q == STREAM) && (rows_q != '0);
    assign last_read = ({1'b0, rd_addr_q} + ROW_ONE) >= rows_q;

    assign feature_port_i.rd_en   = rd_en;
    assign feature_port_i.rd_addr = rd_addr_q;
    assign weight_port_i.rd_en    = rd_en;
    assign weight_port_i.rd_addr  = rd_addr_q;

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q        <= IDLE;
            rows_q         <= '0;
            rd_addr_q      <= '0;
            busy_o         <= 1'b0;
            result_valid_o <= 1'b0;
            final_output_o <= '0;
        end else begin
            result_valid_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        rows_q    <= min_count;
                        rd_addr_q <= '0;
                        busy_o    <= 1'b1;
                        state_q   <= STREAM;
                    end
                end
                STREAM: begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                    if (last_read) begin
                        state_q <= DRAIN;
                    end
                end
                // wait until the last row has left the memory
                DRAIN: begin
                    if (!rd_valid_q) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    final_output_o <= acc_q;
                    result_valid_o <= 1'b1;
                    busy_o         <= 1'b0;
                    state_q        <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lane products, row sum and accumulation
    //////////////////////////////////////////////////////////////////////

    always_comb begin : lane_sum
        logic signed [PROD_WIDTH-1:0] prod;
        row_sum = '0;
        for (int i = 0; i < N_LANES; i++) begin
            prod = $signed(feature_port_i.rd_data[i*LANE_WIDTH +: LANE_WIDTH]) *
                   $signed(weight_port_i.rd_data[i*LANE_WIDTH +: LANE_WIDTH]);
            row_sum = row_sum + ACC_WIDTH'(prod);
        end
    end

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            rd_valid_q  <= 1'b0;
            sum_valid_q <= 1'b0;
        end else begin
            rd_valid_q  <= rd_en;
            sum_valid_q <= rd_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_valid_q) begin
            sum_q <= row_sum;
        end
        // wraps modulo 2^ACC_WIDTH
        if (state_q == IDLE && start_i) begin
            acc_q <= '0;
        end else if (sum_valid_q) begin
            acc_q <= acc_q + sum_q;
        end
    end

    a_result_pulse: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        result_valid_o |=> !result_valid_o)
        else $error("dot_product_engine: result_valid_o longer than one cycle");

    a_read_in_range: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        (feature_port_i.rd_en || weight_port_i.rd_en) |->
            ({1'b0, feature_port_i.rd_addr} < rows_q))
        else $error("dot_product_engine: read beyond latched row count");

endmodule

`default_nettype wire

// ==== rtl/conv_row_accel.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_row_accel #(
    parameter int N_LANES        = accel_pkg::N_LANES,
    parameter int LANE_WIDTH     = accel_pkg::LANE_WIDTH,
    parameter int ROW_ADDR_WIDTH = accel_pkg::ROW_ADDR_WIDTH,
    parameter int ACC_WIDTH      = accel_pkg::ACC_WIDTH
) (
    input  logic                             clk_i,
    input  logic                             rd_weight_rst,
    input  logic [accel_pkg::WORD_WIDTH-1:0] mem_data_i,
    input  logic                             mem_valid_i,
    input  accel_pkg::mem_target_e           mem_target_i,
    input  logic                             load_clear_i,
    input  logic                             start_i,
    output logic                             busy_o,
    output logic                             result_valid_o,
    output accel_pkg::acc_t                  final_output_o
);

    import accel_pkg::*;

    localparam int ROW_BITS = N_LANES * LANE_WIDTH;

    logic feature_valid;
    logic weight_valid;

    // target tag picks the loader
    assign feature_valid = mem_valid_i && (mem_target_i == TGT_FEATURE);
    assign weight_valid  = mem_valid_i && (mem_target_i == TGT_WEIGHT);

    row_port_if #(
        .ROW_ADDR_WIDTH (ROW_ADDR_WIDTH),
        .ROW_WIDTH      (ROW_BITS)
    ) feature_port ();

    row_port_if #(
        .ROW_ADDR_WIDTH (ROW_ADDR_WIDTH),
        .ROW_WIDTH      (ROW_BITS)
    ) weight_port ();

    //////////////////////////////////////////////////////////////////////
    // operand memories
    //////////////////////////////////////////////////////////////////////

    row_loader #(
        .N_LANES        (N_LANES),
        .LANE_WIDTH     (LANE_WIDTH),
        .ROW_ADDR_WIDTH (ROW_ADDR_WIDTH)
    ) i_feature_loader (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .clear_i       (load_clear_i),
        .word_valid_i  (feature_valid),
        .word_i        (mem_data_i),
        .port_o        (feature_port)
    );

    row_loader #(
        .N_LANES        (N_LANES),
        .LANE_WIDTH     (LANE_WIDTH),
        .ROW_ADDR_WIDTH (ROW_ADDR_WIDTH)
    ) i_weight_loader (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .clear_i       (load_clear_i),
        .word_valid_i  (weight_valid),
        .word_i        (mem_data_i),
        .port_o        (weight_port)
    );

    dot_product_engine #(
        .N_LANES        (N_LANES),
        .LANE_WIDTH     (LANE_WIDTH),
        .ROW_ADDR_WIDTH (ROW_ADDR_WIDTH),
        .ACC_WIDTH      (ACC_WIDTH)
    ) i_engine (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .start_i        (start_i),
        .feature_port_i (feature_port),
        .weight_port_i  (weight_port),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .final_output_o (final_output_o)
    );

endmodule

`default_nettype wire

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

typedef logic [ROW_WIDTH-1:0] row_bits_t;

int result_errors = 0;
int flag_errors   = 0;
int count_errors  = 0;
int other_errors  = 0;

// reference copies of both operand memories
row_bits_t feature_rows[$];
row_bits_t weight_rows[$];

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_result(input acc_t got, input acc_t exp, input string what);
    if (got !== exp) begin
        result_errors++;
        $display("CHECK FAILED at %0t: %s: result %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_busy(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        flag_errors++;
        $display("CHECK FAILED at %0t: %s: busy_o %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        flag_errors++;
        $display("CHECK FAILED at %0t: %s: result_valid_o %b, expected %b",
                 $time, what, got, exp);
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
        count_errors++;
        $display("CHECK FAILED at %0t: %s: count %0d, expected %0d", $time, what, got, exp);
    end
endtask

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

// rows beyond the memory depth are dropped, as in the loader
function automatic void store_row(input mem_target_e tgt, input row_bits_t row);
    if (tgt == TGT_FEATURE) begin
        if (feature_rows.size() < (2 ** ROW_ADDR_WIDTH)) feature_rows.push_back(row);
    end else begin
        if (weight_rows.size() < (2 ** ROW_ADDR_WIDTH)) weight_rows.push_back(row);
    end
endfunction

function automatic int model_rows();
    return (feature_rows.size() < weight_rows.size()) ? feature_rows.size() :
                                                        weight_rows.size();
endfunction

// signed lane products summed over rows, wrapping at the accumulator width
function automatic acc_t model_dot();
    acc_t  acc;
    lane_t f;
    lane_t w;
    int    prod;
    acc = '0;
    for (int r = 0; r < model_rows(); r++) begin
        for (int i = 0; i < N_LANES; i++) begin
            f    = feature_rows[r][i*LANE_WIDTH +: LANE_WIDTH];
            w    = weight_rows[r][i*LANE_WIDTH +: LANE_WIDTH];
            prod = f * w;
            acc  = acc + acc_t'(prod);
        end
    end
    return acc;
endfunction

`endif

// ==== test/tb_conv_row_accel.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_row_accel;

    import accel_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int SEED        = 32'hdf6b_d05e;
    localparam int DEPTH       = 2 ** ROW_ADDR_WIDTH;
    // rows pushed over all scenarios, each word at most two cycles
    localparam int ROWS_LOADED = 120;
    localparam int RUNS        = 6;
    localparam int TEST_CYCLES = ROWS_LOADED * WORDS_PER_ROW * 2 + RUNS * (DEPTH + 12);

    logic                  clk_i = 1'b0;
    logic                  rd_weight_rst;
    logic [WORD_WIDTH-1:0] mem_data_i;
    logic                  mem_valid_i;
    mem_target_e           mem_target_i;
    logic                  load_clear_i;
    logic                  start_i;
    logic                  busy_o;
    logic                  result_valid_o;
    acc_t                  final_output_o;

    `include "tb_checks.svh"

    conv_row_accel #(
        .N_LANES        (N_LANES),
        .LANE_WIDTH     (LANE_WIDTH),
        .ROW_ADDR_WIDTH (ROW_ADDR_WIDTH),
        .ACC_WIDTH      (ACC_WIDTH)
    ) i_conv_row_accel (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .mem_data_i     (mem_data_i),
        .mem_valid_i    (mem_valid_i),
        .mem_target_i   (mem_target_i),
        .load_clear_i   (load_clear_i),
        .start_i        (start_i),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .final_output_o (final_output_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic row_bits_t random_row();
        row_bits_t row;
        for (int i = 0; i < N_LANES; i++) row[i*LANE_WIDTH +: LANE_WIDTH] = $urandom;
        return row;
    endfunction

    // every lane is -128 or 127
    function automatic row_bits_t extreme_row();
        row_bits_t row;
        for (int i = 0; i < N_LANES; i++) begin
            row[i*LANE_WIDTH +: LANE_WIDTH] = $urandom_range(0, 1) ? 8'h80 : 8'h7f;
        end
        return row;
    endfunction

    // one word, then sometimes an idle cycle with junk on the bus
    task automatic send_word(input mem_target_e tgt, input logic [WORD_WIDTH-1:0] w);
        mem_target_i = tgt;
        mem_data_i   = w;
        mem_valid_i  = 1'b1;
        @(negedge clk_i);
        mem_valid_i  = 1'b0;
        mem_data_i   = $urandom;
        if ($urandom_range(0, 1)) @(negedge clk_i);
    endtask

    task automatic send_words(input mem_target_e tgt, input row_bits_t row, input int n);
        logic [WORDS_PER_ROW*WORD_WIDTH-1:0] buffer;
        buffer = {$urandom, $urandom, $urandom, $urandom};
        buffer[ROW_WIDTH-1:0] = row;
        for (int k = 0; k < n; k++) send_word(tgt, buffer[k*WORD_WIDTH +: WORD_WIDTH]);
    endtask

    task automatic load_row(input mem_target_e tgt, input row_bits_t row);
        send_words(tgt, row, WORDS_PER_ROW);
        store_row(tgt, row);
    endtask

    task automatic clear_loads();
        load_clear_i = 1'b1;
        @(negedge clk_i);
        load_clear_i = 1'b0;
        feature_rows.delete();
        weight_rows.delete();
    endtask

    // start, watch busy, wait for the result pulse and check it
    task automatic run_engine(input bit extra_start, input string what);
        acc_t expected;
        int   rows;
        int   n;
        int   pulses;
        expected = model_dot();
        rows     = model_rows();
        // let the last row write reach the row count
        repeat (2) @(negedge clk_i);
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        n = 0;
        while (!result_valid_o && n <= rows + 10) begin
            check_busy(busy_o, 1'b1, what);
            start_i = extra_start && (n == 1);
            @(negedge clk_i);
            n++;
        end
        start_i = 1'b0;
        if (!result_valid_o) begin
            other_errors++;
            $display("%s: result_valid_o never came after start_i", what);
        end else begin
            check_count(n, rows + 3, {what, " latency"});
            check_result(final_output_o, expected, what);
            check_busy(busy_o, 1'b0, what);
        end
        // long enough to see a second run that a stray start would cause
        pulses = 0;
        repeat (rows + 4) begin
            @(negedge clk_i);
            if (result_valid_o) pulses++;
        end
        check_count(pulses, 0, {what, " extra result pulses"});
    endtask

    //////////////////////////////////////////////////////////////////////
    // scenarios
    //////////////////////////////////////////////////////////////////////

    initial begin
        row_bits_t row;
        rd_weight_rst = 1'b1;
        mem_data_i    = '0;
        mem_valid_i   = 1'b0;
        mem_target_i  = TGT_FEATURE;
        load_clear_i  = 1'b0;
        start_i       = 1'b0;
        void'($urandom(SEED));
        repeat (3) @(negedge clk_i);
        rd_weight_rst = 1'b0;

        check_busy(busy_o, 1'b0, "after reset");
        check_flag(result_valid_o, 1'b0, "after reset");
        check_result(final_output_o, '0, "after reset");

        load_row(TGT_FEATURE, random_row());
        load_row(TGT_WEIGHT, random_row());
        run_engine(1'b0, "single row");

        // same sign in both operands so the sum runs past 2^23
        clear_loads();
        for (int r = 0; r < 40; r++) begin
            row = extreme_row();
            load_row(TGT_FEATURE, row);
            load_row(TGT_WEIGHT, row);
        end
        run_engine(1'b0, "extreme rows");

        clear_loads();
        for (int r = 0; r < 5; r++) load_row(TGT_FEATURE, random_row());
        for (int r = 0; r < 3; r++) load_row(TGT_WEIGHT, random_row());
        run_engine(1'b0, "unequal row counts");

        clear_loads();
        for (int r = 0; r < 3; r++) load_row(TGT_FEATURE, random_row());
        run_engine(1'b0, "no weight rows");

        // partial row in the feature packer when the clear comes
        clear_loads();
        for (int r = 0; r < 2; r++) begin
            load_row(TGT_FEATURE, random_row());
            load_row(TGT_WEIGHT, random_row());
        end
        send_words(TGT_FEATURE, random_row(), 2);
        clear_loads();
        for (int r = 0; r < 3; r++) begin
            load_row(TGT_FEATURE, random_row());
            load_row(TGT_WEIGHT, random_row());
        end
        run_engine(1'b0, "reload after clear");

        clear_loads();
        for (int r = 0; r < 4; r++) begin
            load_row(TGT_FEATURE, random_row());
            load_row(TGT_WEIGHT, random_row());
        end
        run_engine(1'b1, "start while busy");

        $display("errors: result %0d, flags %0d, counts %0d, other %0d",
                 result_errors, flag_errors, count_errors, other_errors);
        if (result_errors + flag_errors + count_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(2.0 * TEST_CYCLES * CLK_PERIOD);
        $display("simulation timed out before all scenarios finished");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
rtl/accel_pkg.sv
rtl/row_port_if.sv
rtl/row_packer.sv
rtl/row_loader.sv
rtl/dot_product_engine.sv
rtl/conv_row_accel.sv
test/tb_conv_row_accel.sv

// ==== Bender.yml ====
package:
  name: conv_row_accel

sources:
  - files:
      - rtl/accel_pkg.sv
      - rtl/row_port_if.sv
      - rtl/row_packer.sv
      - rtl/row_loader.sv
      - rtl/dot_product_engine.sv
      - rtl/conv_row_accel.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_conv_row_accel.sv
